// ==== flist.f ====
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/fill_fsm.sv
rtl/fill_counter.sv
rtl/main_memory.sv
rtl/mem_system.sv
tests/mem_system_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP ?= mem_system_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -j $(JOBS)
PASS_MSG ?= TEST RESULT: PASS
SIM_BIN ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)" || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/mem_system_tb.sv ====
`default_nettype none

module mem_system_tb;

  localparam int MEM_LATENCY = 4;
  localparam int MEM_DEPTH_LOG2 = 12;
  localparam int MODEL_WORDS = 2 ** MEM_DEPTH_LOG2;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_PAIRS = 4;
  localparam int CYCLES_PER_ENTRY = 40;

  typedef enum {KIND_FETCH, KIND_READ, KIND_WRITE, KIND_DUAL} kind_t;

  // One table row
  // iaddr only matters for the dual miss row
  typedef struct {
    string name;
    kind_t kind;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    cache_pkg::addr_t iaddr;
    bit hit_now;
  } entry_t;

  logic clk = 1'b0;
  logic rst;
  cache_pkg::addr_t inst_addr;
  cache_pkg::word_t inst_data;
  logic inst_stall;
  cache_pkg::addr_t data_addr;
  cache_pkg::word_t data_wdata;
  logic data_read;
  logic data_write;
  cache_pkg::word_t data_rdata;
  logic data_stall;

  entry_t table_q [$];

  // Expected memory contents that start at zero like the DUT memory
  cache_pkg::word_t model_mem [MODEL_WORDS];

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  mem_system #(
    .MEM_LATENCY    (MEM_LATENCY),
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
  ) dut_i (
    .clk        (clk),
    .rst        (rst),
    .inst_addr  (inst_addr),
    .inst_data  (inst_data),
    .inst_stall (inst_stall),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_read  (data_read),
    .data_write (data_write),
    .data_rdata (data_rdata),
    .data_stall (data_stall)
  );

  always #5 clk = ~clk;

  // Run limit set once the table length is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, a stall never cleared", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Word slot of a byte address
  function automatic int model_index(input cache_pkg::addr_t addr);
    return int'(addr[MEM_DEPTH_LOG2:1]);
  endfunction

  function automatic void add_entry(input string name, input kind_t kind,
                                    input cache_pkg::addr_t addr,
                                    input cache_pkg::word_t wdata,
                                    input cache_pkg::addr_t iaddr, input bit hit_now);
    entry_t e;
    e.name = name;
    e.kind = kind;
    e.addr = addr;
    e.wdata = wdata;
    e.iaddr = iaddr;
    e.hit_now = hit_now;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    cache_pkg::addr_t rand_addr [RANDOM_PAIRS];
    // Cold fetch from zeroed memory
    add_entry("fetch_zero", KIND_FETCH, 16'h0000, 16'h0000, 16'h0000, 1'b0);
    // Write-allocate and then hits on the rest of the block
    add_entry("write_miss", KIND_WRITE, 16'h0100, 16'ha5a5, 16'h0000, 1'b0);
    add_entry("read_back", KIND_READ, 16'h0100, 16'h0000, 16'h0000, 1'b1);
    add_entry("read_block_word1", KIND_READ, 16'h0102, 16'h0000, 16'h0000, 1'b1);
    add_entry("read_block_word7", KIND_READ, 16'h010e, 16'h0000, 16'h0000, 1'b1);
    // Index 0x12 with tags 0 and 1
    add_entry("write_conflict_a", KIND_WRITE, 16'h0120, 16'h1111, 16'h0000, 1'b0);
    add_entry("write_conflict_b", KIND_WRITE, 16'h0520, 16'h2222, 16'h0000, 1'b0);
    add_entry("read_conflict_a", KIND_READ, 16'h0120, 16'h0000, 16'h0000, 1'b0);
    add_entry("read_conflict_b", KIND_READ, 16'h0520, 16'h0000, 16'h0000, 1'b0);
    // Code written through the data port and fetched later
    add_entry("write_code_0", KIND_WRITE, 16'h0800, 16'hbeef, 16'h0000, 1'b0);
    add_entry("write_code_1", KIND_WRITE, 16'h0802, 16'hcafe, 16'h0000, 1'b0);
    add_entry("fetch_code_0", KIND_FETCH, 16'h0800, 16'h0000, 16'h0000, 1'b0);
    add_entry("fetch_code_1", KIND_FETCH, 16'h0802, 16'h0000, 16'h0000, 1'b1);
    // 0x0e40 evicts 0x0a40 from the data cache
    // Index 0x24 not yet in the instruction cache
    add_entry("write_dual_data", KIND_WRITE, 16'h0a40, 16'h1234, 16'h0000, 1'b0);
    add_entry("write_dual_code", KIND_WRITE, 16'h0e40, 16'h5678, 16'h0000, 1'b0);
    add_entry("dual_miss", KIND_DUAL, 16'h0a40, 16'h0000, 16'h0e40, 1'b0);
    // Random traffic kept inside 0x1000 to 0x1ffe
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      rand_addr[i] = cache_pkg::addr_t'(32'h1000 | ($urandom & 32'h0ffe));
      add_entry($sformatf("random_write_%0d", i), KIND_WRITE, rand_addr[i],
                cache_pkg::word_t'($urandom), 16'h0000, 1'b0);
    end
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      add_entry($sformatf("random_read_%0d", i), KIND_READ, rand_addr[i],
                16'h0000, 16'h0000, 1'b0);
    end
  endfunction

  task automatic check_value(input string name, input cache_pkg::word_t expected,
                             input cache_pkg::word_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic run_entry(input entry_t e);
    int cycle;
    int data_done;
    int inst_done;
    bit data_wait;
    bit inst_wait;
    logic first_stall;
    @(negedge clk);
    data_read = 1'b0;
    data_write = 1'b0;
    case (e.kind)
      KIND_FETCH: begin
        inst_addr = e.addr;
      end
      KIND_READ: begin
        data_addr = e.addr;
        data_read = 1'b1;
      end
      KIND_WRITE: begin
        data_addr = e.addr;
        data_wdata = e.wdata;
        data_write = 1'b1;
      end
      KIND_DUAL: begin
        inst_addr = e.iaddr;
        data_addr = e.addr;
        data_read = 1'b1;
      end
    endcase
    data_wait = (e.kind != KIND_FETCH);
    inst_wait = (e.kind == KIND_FETCH) || (e.kind == KIND_DUAL);
    data_done = -1;
    inst_done = -1;
    cycle = 0;
    // Sample just after the negedge once outputs settle
    #1;
    if (e.hit_now) begin
      first_stall = (e.kind == KIND_FETCH) ? inst_stall : data_stall;
      checks++;
      assert (!first_stall) else begin
        errors++;
        $display("%s: stall raised on an access to a block already in the cache", e.name);
      end
    end
    while (data_wait || inst_wait) begin
      if (data_wait && !data_stall) begin
        data_wait = 1'b0;
        data_done = cycle;
        // Store commits at the coming edge
        if (e.kind == KIND_WRITE) begin
          model_mem[model_index(e.addr)] = e.wdata;
        end else begin
          check_value(e.name, model_mem[model_index(e.addr)], data_rdata);
        end
      end
      if (inst_wait && !inst_stall) begin
        inst_wait = 1'b0;
        inst_done = cycle;
        check_value(e.name, model_mem[model_index(inst_addr)], inst_data);
      end
      if (data_wait || inst_wait) begin
        @(negedge clk);
        #1;
        cycle++;
      end
    end
    // Data fill goes first
    if (e.kind == KIND_DUAL) begin
      checks++;
      assert (data_done < inst_done) else begin
        errors++;
        $display("%s: data stall fell in cycle %0d, not before instruction stall in %0d",
                 e.name, data_done, inst_done);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h9a58));
    rst = 1'b1;
    inst_addr = '0;
    data_addr = '0;
    data_wdata = '0;
    // Missing data read held through reset
    data_read = 1'b1;
    data_write = 1'b0;
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model_mem[i] = '0;
    end
    build_table();
    cycle_limit = table_q.size() * CYCLES_PER_ENTRY + 100;
    // Both ports miss but no stall may show while reset is held
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checks++;
      assert (!inst_stall && !data_stall) else begin
        errors++;
        $display("Stall raised while reset is high");
      end
    end
    rst = 1'b0;
    data_read = 1'b0;
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/mem_system.sv ====
`default_nettype none

module mem_system #(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_DEPTH_LOG2 = 12
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire cache_pkg::addr_t  inst_addr,
  output cache_pkg::word_t       inst_data,
  output logic                   inst_stall,
  input  wire cache_pkg::addr_t  data_addr,
  input  wire cache_pkg::word_t  data_wdata,
  input  wire                    data_read,
  input  wire                    data_write,
  output cache_pkg::word_t       data_rdata,
  output logic                   data_stall
);

  // Cache lookups
  logic icache_hit;
  logic dcache_hit;
  cache_pkg::word_t icache_rdata;
  cache_pkg::word_t dcache_rdata;

  // Miss requests into the fill logic
  logic data_miss;
  logic inst_miss;

  // Fill control
  logic start;
  logic issue_en;
  logic fill_read;
  logic fill_we;
  logic fill_tag_we;
  logic fill_for_data;
  logic busy;
  cache_pkg::addr_t fill_addr;
  cache_pkg::addr_t fill_word_addr;
  cache_pkg::offset_t issue_offset;
  cache_pkg::offset_t return_offset;
  logic issue_done;
  logic last_return;

  // Memory port
  cache_pkg::addr_t mem_addr;
  cache_pkg::word_t mem_rdata;
  logic mem_valid;

  // Per cache write ports
  logic icache_we;
  logic icache_tag_we;
  logic dcache_we;
  logic dcache_tag_we;
  cache_pkg::addr_t dcache_waddr;
  cache_pkg::word_t dcache_wdata;

  // Store on a hit while no fill owns the port
  logic store_en;

  // No request is taken during reset
  assign inst_miss = !rst && !icache_hit;
  assign data_miss = !rst && (data_read || data_write) && !dcache_hit;

  // Writes also wait out an instruction fill
  assign inst_stall = inst_miss;
  assign data_stall = data_miss || (data_write && busy);

  assign store_en = data_write && dcache_hit && !busy;

  assign inst_data = icache_rdata;
  assign data_rdata = dcache_rdata;

  // Fill words go to whichever cache started the fill
  assign icache_we = fill_we && !fill_for_data;
  assign icache_tag_we = fill_tag_we && !fill_for_data;
  assign dcache_tag_we = fill_tag_we && fill_for_data;

  // Data cache port shared by fill returns and stores
  assign dcache_we = busy ? (fill_we && fill_for_data) : store_en;
  assign dcache_waddr = busy ? fill_word_addr : data_addr;
  assign dcache_wdata = busy ? mem_rdata : data_wdata;

  // Memory address from the fill or the store
  assign mem_addr = busy ? fill_addr : data_addr;

  cache_array icache_i (
    .clk         (clk),
    .rst         (rst),
    .lookup_addr (inst_addr),
    .hit         (icache_hit),
    .rdata       (icache_rdata),
    .word_we     (icache_we),
    .word_addr   (fill_word_addr),
    .word_wdata  (mem_rdata),
    .tag_we      (icache_tag_we)
  );

  cache_array dcache_i (
    .clk         (clk),
    .rst         (rst),
    .lookup_addr (data_addr),
    .hit         (dcache_hit),
    .rdata       (dcache_rdata),
    .word_we     (dcache_we),
    .word_addr   (dcache_waddr),
    .word_wdata  (dcache_wdata),
    .tag_we      (dcache_tag_we)
  );

  fill_fsm fill_fsm_i (
    .clk            (clk),
    .rst            (rst),
    .data_miss      (data_miss),
    .inst_miss      (inst_miss),
    .data_addr      (data_addr),
    .inst_addr      (inst_addr),
    .issue_offset   (issue_offset),
    .return_offset  (return_offset),
    .issue_done     (issue_done),
    .last_return    (last_return),
    .mem_valid      (mem_valid),
    .start          (start),
    .issue_en       (issue_en),
    .mem_read       (fill_read),
    .fill_addr      (fill_addr),
    .fill_word_addr (fill_word_addr),
    .word_we        (fill_we),
    .tag_we         (fill_tag_we),
    .fill_for_data  (fill_for_data),
    .busy           (busy)
  );

  fill_counter fill_counter_i (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .issue_en      (issue_en),
    .mem_valid     (mem_valid),
    .issue_offset  (issue_offset),
    .return_offset (return_offset),
    .issue_done    (issue_done),
    .last_return   (last_return)
  );

  // Write-through data always comes from the requester
  main_memory #(
    .MEM_LATENCY    (MEM_LATENCY),
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
  ) main_memory_i (
    .clk       (clk),
    .rst       (rst),
    .mem_addr  (mem_addr),
    .mem_wdata (data_wdata),
    .mem_read  (fill_read),
    .mem_write (store_en),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid)
  );

endmodule

`default_nettype wire

// ==== rtl/main_memory.sv ====
`default_nettype none

module main_memory #(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_DEPTH_LOG2 = 12
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire cache_pkg::addr_t  mem_addr,
  input  wire cache_pkg::word_t  mem_wdata,
  input  wire                    mem_read,
  input  wire                    mem_write,
  output cache_pkg::word_t       mem_rdata,
  output logic                   mem_valid
);

  localparam int DEPTH = 2 ** MEM_DEPTH_LOG2;

  cache_pkg::word_t mem_array [DEPTH];

  // Word index, byte bit dropped
  logic [MEM_DEPTH_LOG2-1:0] word_index;

  // Read pipeline, one slot per cycle of latency
  cache_pkg::word_t data_pipe [MEM_LATENCY];
  logic [MEM_LATENCY-1:0] valid_pipe;

  assign word_index = mem_addr[MEM_DEPTH_LOG2:1];

  // Block RAM contents start cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem_array[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem_array[word_index] <= mem_wdata;
    end
  end

  // Data moves every cycle, the valid bit tags real reads
  always_ff @(posedge clk) begin
    data_pipe[0] <= mem_array[word_index];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= mem_read;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  assign mem_rdata = data_pipe[MEM_LATENCY-1];
  assign mem_valid = valid_pipe[MEM_LATENCY-1];

  // Fill reads and write-through stores take turns on the port
  one_access_a : assert property (
    @(posedge clk) disable iff (rst) !(mem_read && mem_write)
  );

endmodule

`default_nettype wire

// ==== rtl/fill_counter.sv ====
`default_nettype none

module fill_counter (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,
  input  wire                 issue_en,
  input  wire                 mem_valid,
  output cache_pkg::offset_t  issue_offset,
  output cache_pkg::offset_t  return_offset,
  output logic                issue_done,
  output logic                last_return
);

  // One extra bit so a full block can be counted
  typedef logic [cache_pkg::OFFSET_WIDTH:0] count_t;

  localparam count_t FULL_COUNT = count_t'(cache_pkg::BLOCK_WORDS);
  localparam count_t LAST_COUNT = count_t'(cache_pkg::BLOCK_WORDS - 1);

  count_t issue_cnt_q;
  count_t return_cnt_q;

  // Reads sent to memory
  always_ff @(posedge clk) begin
    if (rst || start) begin
      issue_cnt_q <= '0;
    end else if (issue_en) begin
      issue_cnt_q <= issue_cnt_q + 1'b1;
    end
  end

  // Words back from memory
  always_ff @(posedge clk) begin
    if (rst || start) begin
      return_cnt_q <= '0;
    end else if (mem_valid) begin
      return_cnt_q <= return_cnt_q + 1'b1;
    end
  end

  assign issue_offset = issue_cnt_q[cache_pkg::OFFSET_WIDTH-1:0];
  assign return_offset = return_cnt_q[cache_pkg::OFFSET_WIDTH-1:0];

  // All reads of the block are out
  assign issue_done = (issue_cnt_q == FULL_COUNT);
  // Eighth word arriving now
  assign last_return = mem_valid && (return_cnt_q == LAST_COUNT);

  // Memory never returns a word that was not requested
  returns_follow_issues_a : assert property (
    @(posedge clk) disable iff (rst) return_cnt_q <= issue_cnt_q
  );

endmodule

`default_nettype wire

// ==== rtl/fill_fsm.sv ====
`default_nettype none

module fill_fsm (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      data_miss,
  input  wire                      inst_miss,
  input  wire cache_pkg::addr_t    data_addr,
  input  wire cache_pkg::addr_t    inst_addr,
  input  wire cache_pkg::offset_t  issue_offset,
  input  wire cache_pkg::offset_t  return_offset,
  input  wire                      issue_done,
  input  wire                      last_return,
  input  wire                      mem_valid,
  output logic                     start,
  output logic                     issue_en,
  output logic                     mem_read,
  output cache_pkg::addr_t         fill_addr,
  output cache_pkg::addr_t         fill_word_addr,
  output logic                     word_we,
  output logic                     tag_we,
  output logic                     fill_for_data,
  output logic                     busy
);

  cache_pkg::fill_state_t state_q;
  cache_pkg::fill_state_t state_d;

  // Block being filled
  cache_pkg::tag_t base_tag_q;
  cache_pkg::index_t base_index_q;
  logic for_data_q;

  // Address of the miss chosen at start
  cache_pkg::addr_t miss_addr;

  // Data side wins when both miss together
  assign miss_addr = data_miss ? data_addr : inst_addr;

  assign start = (state_q == cache_pkg::FILL_IDLE) && (data_miss || inst_miss);
  assign busy = (state_q != cache_pkg::FILL_IDLE);

  // One read per cycle while issuing
  assign issue_en = (state_q == cache_pkg::FILL_ISSUE) && !issue_done;
  assign mem_read = issue_en;

  // Read address follows the issue count, write address the return count
  assign fill_addr = cache_pkg::block_addr(base_tag_q, base_index_q, issue_offset);
  assign fill_word_addr = cache_pkg::block_addr(base_tag_q, base_index_q, return_offset);

  // Every returned word goes into the cache
  assign word_we = mem_valid;
  // Last word also commits tag and valid
  assign tag_we = last_return;
  assign fill_for_data = for_data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::FILL_IDLE: begin
        if (start) begin
          state_d = cache_pkg::FILL_ISSUE;
        end
      end
      cache_pkg::FILL_ISSUE: begin
        // Short latency can finish the block before the drain state
        if (last_return) begin
          state_d = cache_pkg::FILL_IDLE;
        end else if (issue_done) begin
          state_d = cache_pkg::FILL_DRAIN;
        end
      end
      cache_pkg::FILL_DRAIN: begin
        if (last_return) begin
          state_d = cache_pkg::FILL_IDLE;
        end
      end
      default: begin
        state_d = cache_pkg::FILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= cache_pkg::FILL_IDLE;
      for_data_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        for_data_q <= data_miss;
      end
    end
  end

  // Block base captured once per fill
  always_ff @(posedge clk) begin
    if (start) begin
      base_tag_q <= cache_pkg::addr_tag(miss_addr);
      base_index_q <= cache_pkg::addr_index(miss_addr);
    end
  end

  // Memory only answers reads issued by a fill
  no_return_when_idle_a : assert property (
    @(posedge clk) disable iff (rst)
    (state_q == cache_pkg::FILL_IDLE) |-> !mem_valid
  );

endmodule

`default_nettype wire

// ==== rtl/cache_array.sv ====
`default_nettype none

module cache_array (
  input  wire                    clk,
  input  wire                    rst,
  input  wire cache_pkg::addr_t  lookup_addr,
  output logic                   hit,
  output cache_pkg::word_t       rdata,
  input  wire                    word_we,
  input  wire cache_pkg::addr_t  word_addr,
  input  wire cache_pkg::word_t  word_wdata,
  input  wire                    tag_we
);

  // Data store index is {set, word offset}
  typedef logic [cache_pkg::INDEX_WIDTH+cache_pkg::OFFSET_WIDTH-1:0] slot_t;

  // Per set metadata
  logic [cache_pkg::SETS-1:0] valid_q;
  cache_pkg::tag_t tag_mem [cache_pkg::SETS];

  // Word storage, one entry per word of every block
  cache_pkg::word_t data_mem [cache_pkg::SETS*cache_pkg::BLOCK_WORDS];

  // Lookup side fields
  cache_pkg::index_t lookup_index;
  cache_pkg::offset_t lookup_offset;
  cache_pkg::tag_t lookup_tag;

  // Write side fields
  cache_pkg::index_t word_index;
  cache_pkg::offset_t word_offset;

  assign lookup_index = cache_pkg::addr_index(lookup_addr);
  assign lookup_offset = cache_pkg::addr_offset(lookup_addr);
  assign lookup_tag = cache_pkg::addr_tag(lookup_addr);

  assign word_index = cache_pkg::addr_index(word_addr);
  assign word_offset = cache_pkg::addr_offset(word_addr);

  // Combinational lookup
  // Hit needs a valid set and a matching tag
  assign hit = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign rdata = data_mem[slot_t'({lookup_index, lookup_offset})];

  // One word per cycle from a fill return or a store
  always_ff @(posedge clk) begin
    if (word_we) begin
      data_mem[slot_t'({word_index, word_offset})] <= word_wdata;
    end
  end

  // Tag written together with the last word of a fill
  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[word_index] <= cache_pkg::addr_tag(word_addr);
    end
  end

  // Valid bits, the only state cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we) begin
      valid_q[word_index] <= 1'b1;
    end
  end

  // Tag commit always rides on the final word write of a fill
  tag_with_word_a : assert property (
    @(posedge clk) disable iff (rst) tag_we |-> word_we
  );

endmodule

`default_nettype wire

// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // Word and address sizes
  localparam int WORD_WIDTH = 16;
  localparam int ADDR_WIDTH = 16;

  // Cache geometry, 8 words per block and 64 sets
  localparam int BLOCK_WORDS = 8;
  localparam int SETS = 64;

  // Address split: tag 15:10, index 9:4, offset 3:1, bit 0 unused
  localparam int OFFSET_WIDTH = 3;
  localparam int INDEX_WIDTH = 6;
  localparam int TAG_WIDTH = 6;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;

  // Fill sequencer states
  typedef enum logic [1:0] {
    FILL_IDLE  = 2'd0,
    FILL_ISSUE = 2'd1,
    FILL_DRAIN = 2'd2
  } fill_state_t;

  // Field extraction
  function automatic offset_t addr_offset(input addr_t addr);
    return addr[OFFSET_WIDTH:1];
  endfunction

  function automatic index_t addr_index(input addr_t addr);
    return addr[OFFSET_WIDTH+INDEX_WIDTH:OFFSET_WIDTH+1];
  endfunction

  function automatic tag_t addr_tag(input addr_t addr);
    return addr[ADDR_WIDTH-1:ADDR_WIDTH-TAG_WIDTH];
  endfunction

  // Rebuild a word address inside a block
  function automatic addr_t block_addr(input tag_t tag, input index_t index, input offset_t offset);
    return {tag, index, offset, 1'b0};
  endfunction

endpackage

`default_nettype wire
